// File: mul_pkg.sv
//////////////////////////////////////////////////
// Shared types and widths for the multiply unit
// Widths are fixed by a 32-bit RISC-V integer datapath
// State encoding is relied on by the bound assertions
//////////////////////////////////////////////////

package mul_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Operand and result width
  localparam int unsigned XLEN   = 32;
  // Halfword plus sign bit
  localparam int unsigned HALF_W = 17;
  // Accumulator holds one shifted partial sum
  localparam int unsigned ACC_W  = 33;
  // Product and adder width
  localparam int unsigned PROD_W = 34;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Operation select
  typedef enum logic {
    MUL_M32 = 1'b0,  // low word, single cycle
    MUL_H   = 1'b1   // high word, four steps
  } mul_opcode_e;

  // MULH step, named after the halves multiplied
  typedef enum logic [1:0] {
    MUL_ALBL = 2'b00,
    MUL_ALBH = 2'b01,
    MUL_AHBL = 2'b10,
    MUL_AHBH = 2'b11
  } mul_state_e;

endpackage

// File: mul_step_if.sv
//////////////////////////////////////////////////
// Per-cycle step controls from the sequencer
// All signals are combinational and valid in the same cycle
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface mul_step_if;

  // Halfword selects for the operand mux
  logic sel_a_hi;
  logic sel_b_hi;

  // Accumulator controls
  logic shift;
  logic acc_load;
  logic acc_clear;

  // Sequencer side
  modport ctrl (output sel_a_hi, sel_b_hi, shift, acc_load, acc_clear);

  // Operand select side
  modport opsel (input sel_a_hi, sel_b_hi);

  // Accumulator side
  modport acc (input shift, acc_load, acc_clear);

endinterface

// File: mul_ctrl.sv
//////////////////////////////////////////////////
// MULH sequencer and strobe decode
// Operands must stay stable until ready_o is seen
// kill_i wins over halt_i, halt_i freezes all state
// MUL never leaves MUL_ALBL
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                valid_i,
  input  logic                halt_i,
  input  logic                kill_i,
  input  logic                ready_i,
  input  mul_pkg::mul_opcode_e operator_i,
  output logic                ready_o,
  output logic                valid_o,
  mul_step_if.ctrl            step
);

  // Step state
  mul_pkg::mul_state_e state_q;
  mul_pkg::mul_state_e state_d;

  // Register enable, advance or abort
  logic update;

  // Local copies of the step controls
  logic sel_a_hi;
  logic sel_b_hi;
  logic shift;
  logic acc_load;
  logic acc_clear;

  assign update = (valid_i && !halt_i) || kill_i;

  //////////////////////////////////////////////////
  // Step and strobe decode
  //////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    valid_o   = 1'b0;
    ready_o   = 1'b0;
    sel_a_hi  = 1'b0;
    sel_b_hi  = 1'b0;
    shift     = 1'b0;
    acc_load  = 1'b0;
    acc_clear = 1'b0;

    // Assumes valid_i high, halt_i and kill_i low
    case (state_q)
      mul_pkg::MUL_ALBL: begin
        if (operator_i == mul_pkg::MUL_H) begin
          // First partial product, shifted down
          shift    = 1'b1;
          acc_load = 1'b1;
          state_d  = mul_pkg::MUL_ALBH;
        end else begin
          // Low word is ready right away
          valid_o = 1'b1;
          ready_o = ready_i;
        end
      end
      mul_pkg::MUL_ALBH: begin
        sel_b_hi = 1'b1;
        acc_load = 1'b1;
        state_d  = mul_pkg::MUL_AHBL;
      end
      mul_pkg::MUL_AHBL: begin
        sel_a_hi = 1'b1;
        shift    = 1'b1;
        acc_load = 1'b1;
        state_d  = mul_pkg::MUL_AHBH;
      end
      mul_pkg::MUL_AHBH: begin
        // Final sum drives the result, held under back-pressure
        sel_a_hi = 1'b1;
        sel_b_hi = 1'b1;
        valid_o  = 1'b1;
        if (ready_i) begin
          ready_o   = 1'b1;
          acc_clear = 1'b1;
          state_d   = mul_pkg::MUL_ALBL;
        end
      end
      default: state_d = mul_pkg::MUL_ALBL;
    endcase

    // Idle or abort, back to the first step
    if (!valid_i || kill_i) begin
      state_d   = mul_pkg::MUL_ALBL;
      valid_o   = 1'b0;
      ready_o   = 1'b1;
      sel_a_hi  = 1'b0;
      sel_b_hi  = 1'b0;
      shift     = 1'b0;
      acc_load  = 1'b0;
      acc_clear = 1'b1;
    end else if (halt_i) begin
      // Frozen, nothing moves
      state_d   = state_q;
      valid_o   = 1'b0;
      ready_o   = 1'b0;
      acc_load  = 1'b0;
      acc_clear = 1'b0;
    end
  end

  assign step.sel_a_hi  = sel_a_hi;
  assign step.sel_b_hi  = sel_b_hi;
  assign step.shift     = shift;
  assign step.acc_load  = acc_load;
  assign step.acc_clear = acc_clear;

  // State register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mul_pkg::MUL_ALBL;
    end else if (update) begin
      state_q <= state_d;
    end
  end

endmodule

// File: mul_operand_sel.sv
//////////////////////////////////////////////////
// Multiplier operand select
// Low halves are unsigned, high halves follow signed_mode_i
// MUL bypasses the halfword path
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_operand_sel (
  input  mul_pkg::mul_opcode_e       operator_i,
  input  logic [1:0]                 signed_mode_i,
  input  logic [mul_pkg::XLEN-1:0]   op_a_i,
  input  logic [mul_pkg::XLEN-1:0]   op_b_i,
  mul_step_if.opsel                  step,
  output logic [mul_pkg::XLEN-1:0]   mul_a_o,
  output logic [mul_pkg::XLEN-1:0]   mul_b_o
);

  // Halves with their 17th bit
  logic [mul_pkg::HALF_W-1:0] a_lo;
  logic [mul_pkg::HALF_W-1:0] a_hi;
  logic [mul_pkg::HALF_W-1:0] b_lo;
  logic [mul_pkg::HALF_W-1:0] b_hi;

  // Halves chosen for this step
  logic [mul_pkg::HALF_W-1:0] half_a;
  logic [mul_pkg::HALF_W-1:0] half_b;

  // Lower halfwords always zero-extended
  assign a_lo = {1'b0, op_a_i[15:0]};
  assign b_lo = {1'b0, op_b_i[15:0]};

  // Bit 0 signs operand a, bit 1 signs operand b
  assign a_hi = {signed_mode_i[0] & op_a_i[31], op_a_i[31:16]};
  assign b_hi = {signed_mode_i[1] & op_b_i[31], op_b_i[31:16]};

  assign half_a = step.sel_a_hi ? a_hi : a_lo;
  assign half_b = step.sel_b_hi ? b_hi : b_lo;

  // Full operands for MUL, sign-extended halves otherwise
  assign mul_a_o = (operator_i == mul_pkg::MUL_M32) ? op_a_i :
                   {{(mul_pkg::XLEN - mul_pkg::HALF_W){half_a[mul_pkg::HALF_W-1]}}, half_a};
  assign mul_b_o = (operator_i == mul_pkg::MUL_M32) ? op_b_i :
                   {{(mul_pkg::XLEN - mul_pkg::HALF_W){half_b[mul_pkg::HALF_W-1]}}, half_b};

endmodule

// File: mul_accum.sv
//////////////////////////////////////////////////
// Signed multiplier, adder and MULH accumulator
// Accumulator must be zero whenever MUL is issued
// acc_clear wins over acc_load
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_accum (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [mul_pkg::XLEN-1:0]   mul_a_i,
  input  logic [mul_pkg::XLEN-1:0]   mul_b_i,
  mul_step_if.acc                    step,
  output logic [mul_pkg::XLEN-1:0]   result_o
);

  // Sign-extended operands
  logic signed [mul_pkg::PROD_W-1:0] a_ext;
  logic signed [mul_pkg::PROD_W-1:0] b_ext;

  // Product, sum and shifted sum
  logic signed [mul_pkg::PROD_W-1:0] product;
  logic signed [mul_pkg::PROD_W-1:0] sum;
  logic signed [mul_pkg::PROD_W-1:0] sum_shifted;

  // Accumulator
  logic [mul_pkg::ACC_W-1:0] acc_q;
  logic [mul_pkg::ACC_W-1:0] acc_d;

  assign a_ext = {{(mul_pkg::PROD_W - mul_pkg::XLEN){mul_a_i[mul_pkg::XLEN-1]}}, mul_a_i};
  assign b_ext = {{(mul_pkg::PROD_W - mul_pkg::XLEN){mul_b_i[mul_pkg::XLEN-1]}}, mul_b_i};

  // Low 34 bits of the signed product
  assign product = a_ext * b_ext;

  // 34-bit adder, accumulator sign-extended by one bit
  assign sum = product + $signed({acc_q[mul_pkg::ACC_W-1], acc_q});

  // Drop one halfword for the next partial product
  assign sum_shifted = sum >>> (mul_pkg::HALF_W - 1);

  assign acc_d = step.shift ? sum_shifted[mul_pkg::ACC_W-1:0] : sum[mul_pkg::ACC_W-1:0];

  // Low word for MUL, high word after the last MULH step
  assign result_o = sum[mul_pkg::XLEN-1:0];

  //////////////////////////////////////////////////
  // Accumulator register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (step.acc_clear) begin
      acc_q <= '0;
    end else if (step.acc_load) begin
      acc_q <= acc_d;
    end
  end

endmodule

// File: mul_top.sv
//////////////////////////////////////////////////
// Integer multiply unit top level
// MUL in one cycle, MULH/MULHSU/MULHU in four steps
// Issuing stage holds inputs until ready_o is seen
// No cycles are added at this level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       valid_i,
  input  logic                       halt_i,
  input  logic                       kill_i,
  input  logic                       ready_i,
  input  mul_pkg::mul_opcode_e       operator_i,
  input  logic [1:0]                 signed_mode_i,
  input  logic [mul_pkg::XLEN-1:0]   op_a_i,
  input  logic [mul_pkg::XLEN-1:0]   op_b_i,
  output logic [mul_pkg::XLEN-1:0]   result_o,
  output logic                       ready_o,
  output logic                       valid_o
);

  // Multiplier operands after select
  logic [mul_pkg::XLEN-1:0] mul_a;
  logic [mul_pkg::XLEN-1:0] mul_b;

  // Step controls shared by the datapath
  mul_step_if step_if ();

  // Sequencer and strobes
  mul_ctrl mul_ctrl_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .halt_i     (halt_i),
    .kill_i     (kill_i),
    .ready_i    (ready_i),
    .operator_i (operator_i),
    .ready_o    (ready_o),
    .valid_o    (valid_o),
    .step       (step_if)
  );

  // Halfword split and extension
  mul_operand_sel mul_operand_sel_inst (
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .step          (step_if),
    .mul_a_o       (mul_a),
    .mul_b_o       (mul_b)
  );

  // Multiply, add and accumulate
  mul_accum mul_accum_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .mul_a_i  (mul_a),
    .mul_b_i  (mul_b),
    .step     (step_if),
    .result_o (result_o)
  );

endmodule

// File: mul_top_sva.sv
//////////////////////////////////////////////////
// Strobe protocol assertions bound to mul_top
// Step state is taken from the sequencer inside the DUT
//////////////////////////////////////////////////

`timescale 1ns/1ps

module mul_top_sva (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 valid_i,
  input logic                 halt_i,
  input logic                 kill_i,
  input logic                 ready_i,
  input mul_pkg::mul_opcode_e operator_i,
  input logic [31:0]          result_o,
  input logic                 ready_o,
  input logic                 valid_o,
  input logic [1:0]           state_i
);

  // Advancing cycles of the operation in flight, saturates at three
  logic [1:0] adv_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      adv_cnt <= 2'd0;
    end else if (!valid_i || kill_i || ready_o) begin
      adv_cnt <= 2'd0;
    end else if (!halt_i && adv_cnt != 2'd3) begin
      adv_cnt <= adv_cnt + 2'd1;
    end
  end

  // Idle unit always consumes
  a_idle_ready: assert property (@(posedge clk) disable iff (!rst_n)
    !valid_i |-> ready_o)
    else $error("ready_o low while valid_i low");

  a_valid_issue: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> valid_i && !halt_i)
    else $error("valid_o without an advancing issue");

  // MULH result only after three advancing cycles
  a_mulh_latency: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && operator_i == mul_pkg::MUL_H |-> adv_cnt == 2'd3)
    else $error("MULH valid_o before three advancing cycles");

  // Each step entered from the one before on an advancing cycle
  a_step_order: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i != $past(state_i)) && (state_i != mul_pkg::MUL_ALBL) |->
      $past(valid_i && !halt_i && !kill_i) && (state_i == $past(state_i) + 2'd1))
    else $error("MULH step skipped or taken without advance");

  // Result held under back-pressure
  a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i |=> !valid_i || kill_i || $stable(result_o))
    else $error("result_o changed under back-pressure");

endmodule

bind mul_top mul_top_sva mul_top_sva_inst (
  .clk        (clk),
  .rst_n      (rst_n),
  .valid_i    (valid_i),
  .halt_i     (halt_i),
  .kill_i     (kill_i),
  .ready_i    (ready_i),
  .operator_i (operator_i),
  .result_o   (result_o),
  .ready_o    (ready_o),
  .valid_o    (valid_o),
  .state_i    (mul_ctrl_inst.state_q)
);

// File: tb_mul_top.sv
//////////////////////////////////////////////////
// Testbench for the integer multiply unit
// Random MUL and MULH traffic with halt, kill and back-pressure
// Outputs are sampled on the falling edge
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mul_top;

  // Run length and timing
  localparam int CLK_PERIOD     = 4;
  localparam int RESET_CYCLES   = 4;
  localparam int NUM_OPS        = 400;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + RESET_CYCLES;

  // DUT ports
  logic                 clk;
  logic                 rst_n;
  logic                 valid_i;
  logic                 halt_i;
  logic                 kill_i;
  logic                 ready_i;
  mul_pkg::mul_opcode_e operator_i;
  logic [1:0]           signed_mode_i;
  logic [31:0]          op_a_i;
  logic [31:0]          op_b_i;
  logic [31:0]          result_o;
  logic                 ready_o;
  logic                 valid_o;

  // Random state
  integer seed;

  mul_top mul_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .halt_i        (halt_i),
    .kill_i        (kill_i),
    .ready_i       (ready_i),
    .operator_i    (operator_i),
    .signed_mode_i (signed_mode_i),
    .op_a_i        (op_a_i),
    .op_b_i        (op_b_i),
    .result_o      (result_o),
    .ready_o       (ready_o),
    .valid_o       (valid_o)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Reference model and checking
  //////////////////////////////////////////////////

  // Full 64-bit product, each operand extended by its mode bit
  function automatic logic [31:0] ref_result(input mul_pkg::mul_opcode_e op,
                                             input logic [1:0] mode,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] a_x;
    logic [63:0] b_x;
    logic [63:0] prod;
    a_x  = {{32{mode[0] & a[31]}}, a};
    b_x  = {{32{mode[1] & b[31]}}, b};
    prod = a_x * b_x;
    if (op == mul_pkg::MUL_M32) begin
      return prod[31:0];
    end
    return prod[63:32];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got 0x%h expected 0x%h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Corner values half the time, plain random otherwise
  function logic [31:0] pick_operand();
    int sel;
    sel = $random(seed) & 15;
    case (sel)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      4:       return 32'h7fff_ffff;
      5:       return 32'h0000_ffff;
      6:       return 32'hffff_0000;
      7:       return 32'h0000_8000;
      default: return $random(seed);
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  // One cycle with valid_i low, unit must sit idle and ready
  task automatic idle_cycle();
    @(posedge clk);
    valid_i    <= 1'b0;
    kill_i     <= 1'b0;
    halt_i     <= (($random(seed) & 1) != 0);
    ready_i    <= (($random(seed) & 1) != 0);
    op_a_i     <= $random(seed);
    op_b_i     <= $random(seed);
    @(negedge clk);
    check_value("valid_o", {31'd0, valid_o}, 32'd0);
    check_value("ready_o", {31'd0, ready_o}, 32'd1);
  endtask

  // Holds one operation until ready_o, kill_step picks the aborted step
  task automatic run_op(input mul_pkg::mul_opcode_e op, input logic [1:0] mode,
                        input logic [31:0] a, input logic [31:0] b,
                        input bit do_kill, input int kill_step);
    logic [31:0] expected;
    int          adv;
    bit          done;
    logic        halt_now;
    logic        ready_now;
    logic        kill_now;
    logic        exp_valid;
    logic        exp_ready;
    expected = ref_result(op, mode, a, b);
    adv      = 0;
    done     = 1'b0;
    while (!done) begin
      @(posedge clk);
      halt_now  = (($random(seed) & 3) == 0);
      ready_now = (($random(seed) & 3) != 0);
      kill_now  = do_kill && (adv == kill_step);
      valid_i       <= 1'b1;
      operator_i    <= op;
      signed_mode_i <= mode;
      op_a_i        <= a;
      op_b_i        <= b;
      halt_i        <= halt_now;
      ready_i       <= ready_now;
      kill_i        <= kill_now;
      @(negedge clk);
      // MUL is ready at once, MULH after three advancing cycles
      exp_valid = !kill_now && !halt_now && (op == mul_pkg::MUL_M32 || adv >= 3);
      exp_ready = kill_now || (exp_valid && ready_now);
      check_value("valid_o", {31'd0, valid_o}, {31'd0, exp_valid});
      check_value("ready_o", {31'd0, ready_o}, {31'd0, exp_ready});
      if (exp_valid) begin
        check_value("result_o", result_o, expected);
      end
      if (exp_ready) begin
        done = 1'b1;
      end else if (!halt_now && adv < 3) begin
        adv++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    mul_pkg::mul_opcode_e op;
    logic [1:0]           mode;
    int                   gap;
    bit                   do_kill;
    seed          = 32'ha558_60ab;
    rst_n         = 1'b0;
    valid_i       = 1'b0;
    halt_i        = 1'b0;
    kill_i        = 1'b0;
    ready_i       = 1'b0;
    operator_i    = mul_pkg::MUL_M32;
    signed_mode_i = 2'b00;
    op_a_i        = '0;
    op_b_i        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    // Idle after reset
    @(negedge clk);
    check_value("valid_o", {31'd0, valid_o}, 32'd0);
    check_value("ready_o", {31'd0, ready_o}, 32'd1);
    for (int i = 0; i < NUM_OPS; i++) begin
      gap = $random(seed) & 3;
      repeat (gap) idle_cycle();
      op = (($random(seed) & 1) != 0) ? mul_pkg::MUL_H : mul_pkg::MUL_M32;
      case ($random(seed) & 3)
        0:       mode = 2'b11;
        1:       mode = 2'b01;
        default: mode = 2'b00;
      endcase
      do_kill = (op == mul_pkg::MUL_H) && (($random(seed) & 7) == 0);
      run_op(op, mode, pick_operand(), pick_operand(), do_kill, $random(seed) & 3);
    end
    idle_cycle();
    $display("** PASS **");
    $finish;
  end

  // Watchdog sized from the operation count
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("** FAIL **");
    $fatal(1, "watchdog expired before all operations completed");
  end

endmodule

// File: compile.f
mul_pkg.sv
mul_step_if.sv
mul_ctrl.sv
mul_operand_sel.sv
mul_accum.sv
mul_top.sv
mul_top_sva.sv
tb_mul_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_mul_top
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
